// File: verilog/cv_input_pkg.sv
// Input side types: PS/2 scan codes, keypad line codes, keyboard and controller structs
package cv_input_pkg;

	typedef logic [7:0] scan_code_t;  // PS/2 set 2 code
	typedef logic [3:0] key_nibble_t; // Controller line code

	// --------------------
	// Scan codes
	localparam scan_code_t SC_0      = 8'h45;
	localparam scan_code_t SC_1      = 8'h16;
	localparam scan_code_t SC_2      = 8'h1E;
	localparam scan_code_t SC_3      = 8'h26;
	localparam scan_code_t SC_4      = 8'h25;
	localparam scan_code_t SC_5      = 8'h2E;
	localparam scan_code_t SC_6      = 8'h36;
	localparam scan_code_t SC_7      = 8'h3D;
	localparam scan_code_t SC_8      = 8'h3E;
	localparam scan_code_t SC_9      = 8'h46;
	localparam scan_code_t SC_STAR   = 8'h7C; // Keypad *
	localparam scan_code_t SC_MINUS  = 8'h7B; // Keypad -
	localparam scan_code_t SC_LSHIFT = 8'h12;
	localparam scan_code_t SC_RSHIFT = 8'h59;
	localparam scan_code_t SC_UP     = 8'h75;
	localparam scan_code_t SC_DOWN   = 8'h72;
	localparam scan_code_t SC_LEFT   = 8'h6B;
	localparam scan_code_t SC_RIGHT  = 8'h74;
	localparam scan_code_t SC_FIRE1  = 8'h1A; // Z
	localparam scan_code_t SC_FIRE2  = 8'h22; // X
	localparam scan_code_t SC_CTRL   = 8'h14;
	localparam scan_code_t SC_ALT    = 8'h11;
	localparam scan_code_t SC_DEL    = 8'h71;

	// --------------------
	// Keypad codes as the console reads them
	localparam key_nibble_t KEY_0      = 4'b0011;
	localparam key_nibble_t KEY_1      = 4'b1110;
	localparam key_nibble_t KEY_2      = 4'b1101;
	localparam key_nibble_t KEY_3      = 4'b0110;
	localparam key_nibble_t KEY_4      = 4'b0001;
	localparam key_nibble_t KEY_5      = 4'b1001;
	localparam key_nibble_t KEY_6      = 4'b0111;
	localparam key_nibble_t KEY_7      = 4'b1100;
	localparam key_nibble_t KEY_8      = 4'b1000;
	localparam key_nibble_t KEY_9      = 4'b1011;
	localparam key_nibble_t KEY_STAR   = 4'b1010;
	localparam key_nibble_t KEY_NUMBER = 4'b0101;
	localparam key_nibble_t KEY_PT     = 4'b0100;
	localparam key_nibble_t KEY_BT     = 4'b0010;
	localparam key_nibble_t KEY_NONE   = 4'b1111; // Nothing pressed

	// Bit positions of the non-digit keys in pad_t.keys
	localparam int KEY_IDX_STAR   = 10;
	localparam int KEY_IDX_NUMBER = 11;
	localparam int KEY_IDX_PT     = 12;
	localparam int KEY_IDX_BT     = 13;

	// --------------------
	// Held keyboard buttons
	typedef struct packed {
		logic [9:0] digits; // Bit n is digit n
		logic       star;
		logic       minus;
		logic       shift;  // Either shift key
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       fire1;
		logic       fire2;
		logic       ctrl;
		logic       alt;
		logic       del;
	} kbd_btn_t;

	// One controller, active high
	typedef struct packed {
		logic        up;
		logic        down;
		logic        left;
		logic        right;
		logic        fire1;
		logic        fire2;
		logic [13:0] keys; // 0-9, star, number, pt, bt
	} pad_t;

	typedef struct packed {
		logic keypad_sel_n;
		logic joy_sel_n;
	} port_sel_t;

	typedef struct packed {
		key_nibble_t lines;
		logic        fire_n;
	} port_out_t;

endpackage

// File: verilog/cv_sys_pkg.sv
// System side types: configuration register map, RAM size enum, memory and loader widths
package cv_sys_pkg;

	localparam int CPU_ADDR_W   = 15;
	localparam int IOCTL_ADDR_W = 25;
	localparam int CART_PAGES_W = 6;

	typedef logic [CPU_ADDR_W-1:0]   cpu_addr_t;
	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [CART_PAGES_W-1:0] cart_pages_t;

	typedef enum logic [1:0] {
		RAM_1K  = 2'd0,
		RAM_8K  = 2'd1,
		RAM_SGM = 2'd2  // 32K, or 8K on SG-1000
	} ram_size_e;

	// Register 0 layout, LSB first
	typedef struct packed {
		ram_size_e ram_size;      // Bits 3:2
		logic      swap_joy;      // Bit 1
		logic      console_reset; // Bit 0
	} cfg_t;

	// --------------------
	// Register map
	localparam logic [1:0] CFG_ADDR_CTRL = 2'd0;

	// --------------------
	// Loader
	localparam logic [4:0] SG1000_INDEX     = 5'd2; // Menu index of SG-1000 images
	localparam int         EXTRAM_BLOCK_LSB = 13;   // 8 KB blocks
	localparam int         CART_PAGES_LSB   = 14;   // 16 KB pages

	// 8 KB block at 2000h
	localparam logic [IOCTL_ADDR_W-EXTRAM_BLOCK_LSB-1:0] EXTRAM_BLOCK = 1;

	// RAM address masks
	localparam cpu_addr_t RAM_MASK_1K = 15'h03FF;
	localparam cpu_addr_t RAM_MASK_8K = 15'h1FFF;

endpackage

// File: verilog/cv_cfg_regs.sv
// Wishbone configuration register slave and console soft reset generator
module cv_cfg_regs (
	input  logic                   clk_sys,
	input  logic                   rst_n_i,

	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [1:0]             wb_adr_i,
	input  logic [7:0]             wb_dat_i,
	output logic [7:0]             wb_dat_o,
	output logic                   wb_ack_o,

	input  cv_input_pkg::kbd_btn_t kbd_i,
	input  logic                   download_i,

	output cv_sys_pkg::cfg_t       cfg_o,
	output logic                   console_reset_o
);

	logic                  ack_q;
	logic                  access;
	cv_sys_pkg::cfg_t      cfg_q;
	cv_sys_pkg::ram_size_e ram_size_prev;
	logic                  reset_q;
	logic                  kbd_reset;

	// --------------------
	// Bus slave
	assign access = wb_cyc_i & wb_stb_i & ~ack_q; // Single-cycle ack, then idle

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			cfg_q <= '0;
		end else begin
			ack_q <= access;
			if (access && wb_we_i && wb_adr_i == cv_sys_pkg::CFG_ADDR_CTRL) begin
				cfg_q <= cv_sys_pkg::cfg_t'(wb_dat_i[$bits(cv_sys_pkg::cfg_t)-1:0]); // Visible with ack
			end
		end
	end

	always_comb begin
		wb_dat_o = '0;
		if (wb_adr_i == cv_sys_pkg::CFG_ADDR_CTRL) begin
			wb_dat_o[$bits(cv_sys_pkg::cfg_t)-1:0] = cfg_q;
		end
	end

	assign wb_ack_o = ack_q;
	assign cfg_o    = cfg_q;

	// --------------------
	// Soft reset
	assign kbd_reset = kbd_i.ctrl & kbd_i.alt & kbd_i.del; // Three-finger salute

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ram_size_prev <= cv_sys_pkg::RAM_1K;
			reset_q       <= 1'b0;
		end else begin
			ram_size_prev <= cfg_q.ram_size;
			reset_q       <= cfg_q.console_reset
				| (ram_size_prev != cfg_q.ram_size) // RAM size changed
				| kbd_reset
				| download_i;
		end
	end

	assign console_reset_o = reset_q;

endmodule

// File: verilog/cv_key_decoder.sv
// PS/2 key event decoder holding keypad, direction, fire and control key states
module cv_key_decoder (
	input  logic                     clk_sys,
	input  logic                     rst_n_i,

	input  cv_input_pkg::scan_code_t key_code_i,
	input  logic                     key_pressed_i,
	input  logic                     key_strobe_i, // Toggles once per event

	output cv_input_pkg::kbd_btn_t   kbd_o
);

	logic                   strobe_q;
	logic                   event_seen;
	cv_input_pkg::kbd_btn_t kbd_q;

	assign event_seen = strobe_q ^ key_strobe_i;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			strobe_q <= 1'b0;
			kbd_q    <= '0;
		end else begin
			strobe_q <= key_strobe_i;
			if (event_seen) begin
				case (key_code_i)
					// Main row digits
					cv_input_pkg::SC_0:      kbd_q.digits[0] <= key_pressed_i;
					cv_input_pkg::SC_1:      kbd_q.digits[1] <= key_pressed_i;
					cv_input_pkg::SC_2:      kbd_q.digits[2] <= key_pressed_i;
					cv_input_pkg::SC_3:      kbd_q.digits[3] <= key_pressed_i;
					cv_input_pkg::SC_4:      kbd_q.digits[4] <= key_pressed_i;
					cv_input_pkg::SC_5:      kbd_q.digits[5] <= key_pressed_i;
					cv_input_pkg::SC_6:      kbd_q.digits[6] <= key_pressed_i;
					cv_input_pkg::SC_7:      kbd_q.digits[7] <= key_pressed_i;
					cv_input_pkg::SC_8:      kbd_q.digits[8] <= key_pressed_i;
					cv_input_pkg::SC_9:      kbd_q.digits[9] <= key_pressed_i;
					cv_input_pkg::SC_STAR:   kbd_q.star      <= key_pressed_i;
					cv_input_pkg::SC_MINUS:  kbd_q.minus     <= key_pressed_i;
					cv_input_pkg::SC_LSHIFT: kbd_q.shift     <= key_pressed_i;
					cv_input_pkg::SC_RSHIFT: kbd_q.shift     <= key_pressed_i;
					// Cursor keys and fires
					cv_input_pkg::SC_UP:     kbd_q.up        <= key_pressed_i;
					cv_input_pkg::SC_DOWN:   kbd_q.down      <= key_pressed_i;
					cv_input_pkg::SC_LEFT:   kbd_q.left      <= key_pressed_i;
					cv_input_pkg::SC_RIGHT:  kbd_q.right     <= key_pressed_i;
					cv_input_pkg::SC_FIRE1:  kbd_q.fire1     <= key_pressed_i;
					cv_input_pkg::SC_FIRE2:  kbd_q.fire2     <= key_pressed_i;
					// Reset combination
					cv_input_pkg::SC_CTRL:   kbd_q.ctrl      <= key_pressed_i;
					cv_input_pkg::SC_ALT:    kbd_q.alt       <= key_pressed_i;
					cv_input_pkg::SC_DEL:    kbd_q.del       <= key_pressed_i;
					default: begin
						kbd_q <= kbd_q; // Unmapped key
					end
				endcase
			end
		end
	end

	assign kbd_o = kbd_q;

endmodule

// File: verilog/cv_ctrl_ports.sv
// Controller ports: pad registers, joystick swap, keyboard merge and keypad/joystick encoders
module cv_ctrl_ports (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,

	input  cv_input_pkg::pad_t      joy_a_i,
	input  cv_input_pkg::pad_t      joy_b_i,
	input  cv_input_pkg::kbd_btn_t  kbd_i,
	input  logic                    swap_i,

	input  cv_input_pkg::port_sel_t sel_a_i,
	input  cv_input_pkg::port_sel_t sel_b_i,
	output cv_input_pkg::port_out_t port_a_o,
	output cv_input_pkg::port_out_t port_b_o
);

	cv_input_pkg::pad_t joy_a_q;
	cv_input_pkg::pad_t joy_b_q;
	cv_input_pkg::pad_t kbd_pad;
	cv_input_pkg::pad_t joy_b_kbd;
	cv_input_pkg::pad_t pad_a;
	cv_input_pkg::pad_t pad_b;
	logic [13:0]        kbd_keys;

	// Lowest key index wins
	function automatic cv_input_pkg::key_nibble_t keypad_code(logic [13:0] keys);
		if (keys[0]) return cv_input_pkg::KEY_0;
		else if (keys[1]) return cv_input_pkg::KEY_1;
		else if (keys[2]) return cv_input_pkg::KEY_2;
		else if (keys[3]) return cv_input_pkg::KEY_3;
		else if (keys[4]) return cv_input_pkg::KEY_4;
		else if (keys[5]) return cv_input_pkg::KEY_5;
		else if (keys[6]) return cv_input_pkg::KEY_6;
		else if (keys[7]) return cv_input_pkg::KEY_7;
		else if (keys[8]) return cv_input_pkg::KEY_8;
		else if (keys[9]) return cv_input_pkg::KEY_9;
		else if (keys[cv_input_pkg::KEY_IDX_STAR]) return cv_input_pkg::KEY_STAR;
		else if (keys[cv_input_pkg::KEY_IDX_NUMBER]) return cv_input_pkg::KEY_NUMBER;
		else if (keys[cv_input_pkg::KEY_IDX_PT]) return cv_input_pkg::KEY_PT;
		else if (keys[cv_input_pkg::KEY_IDX_BT]) return cv_input_pkg::KEY_BT;
		else return cv_input_pkg::KEY_NONE;
	endfunction

	// Both selects low gives the AND of the two modes
	function automatic cv_input_pkg::port_out_t encode_port(
		cv_input_pkg::pad_t      pad,
		cv_input_pkg::port_sel_t sel
	);
		cv_input_pkg::port_out_t kp;
		cv_input_pkg::port_out_t js;
		kp = '1;
		js = '1;
		if (!sel.keypad_sel_n) begin
			kp.lines  = keypad_code(pad.keys);
			kp.fire_n = ~pad.fire2;
		end
		if (!sel.joy_sel_n) begin
			js.lines  = ~{pad.up, pad.right, pad.down, pad.left};
			js.fire_n = ~pad.fire1;
		end
		return cv_input_pkg::port_out_t'(kp & js);
	endfunction

	// --------------------
	// Pad input registers
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			joy_a_q <= '0;
			joy_b_q <= '0;
		end else begin
			joy_a_q <= joy_a_i;
			joy_b_q <= joy_b_i;
		end
	end

	// --------------------
	// Keyboard merge and swap
	always_comb begin
		kbd_pad       = '0;
		kbd_pad.up    = kbd_i.up;
		kbd_pad.down  = kbd_i.down;
		kbd_pad.left  = kbd_i.left;
		kbd_pad.right = kbd_i.right;
		kbd_pad.fire1 = kbd_i.fire1;
		kbd_pad.fire2 = kbd_i.fire2;
		joy_b_kbd     = cv_input_pkg::pad_t'(joy_b_q | kbd_pad); // Keyboard plays as B

		kbd_keys       = '0;
		kbd_keys[9:0]  = kbd_i.digits;
		kbd_keys[cv_input_pkg::KEY_IDX_STAR]   = kbd_i.star | (kbd_i.shift & kbd_i.digits[8]);
		kbd_keys[cv_input_pkg::KEY_IDX_NUMBER] = kbd_i.minus | (kbd_i.shift & kbd_i.digits[3]);

		pad_a      = swap_i ? joy_b_kbd : joy_a_q;
		pad_b      = swap_i ? joy_a_q : joy_b_kbd;
		pad_a.keys = pad_a.keys | kbd_keys; // Keypad reaches both players
		pad_b.keys = pad_b.keys | kbd_keys;
	end

	assign port_a_o = encode_port(pad_a, sel_a_i);
	assign port_b_o = encode_port(pad_b, sel_b_i);

endmodule

// File: verilog/cv_mem_map.sv
// Cartridge download tracking (SG-1000, extra RAM, page count) and CPU RAM address masking
module cv_mem_map (
	input  logic                    clk_sys,
	input  logic                    rst_n_i,

	input  logic                    ioctl_wr_i,
	input  cv_sys_pkg::ioctl_addr_t ioctl_addr_i,
	input  logic [7:0]              ioctl_dout_i,
	input  logic [7:0]              ioctl_index_i,

	input  cv_sys_pkg::ram_size_e   ram_size_i,
	input  cv_sys_pkg::cpu_addr_t   cpu_ram_a_i,
	output cv_sys_pkg::cpu_addr_t   ram_a_o,

	output logic                    sg1000_o,
	output logic                    extram_o,
	output cv_sys_pkg::cart_pages_t cart_pages_o
);

	logic                    sg1000_q;
	logic                    extram_q;
	cv_sys_pkg::cart_pages_t cart_pages_q;
	logic                    first_byte;
	logic                    in_extram_blk;

	assign first_byte    = (ioctl_addr_i == '0);
	assign in_extram_blk = (ioctl_addr_i[cv_sys_pkg::IOCTL_ADDR_W-1:cv_sys_pkg::EXTRAM_BLOCK_LSB]
		== cv_sys_pkg::EXTRAM_BLOCK);

	// --------------------
	// Loader tracking
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sg1000_q     <= 1'b0;
			extram_q     <= 1'b0;
			cart_pages_q <= '0;
		end else if (ioctl_wr_i) begin
			if (first_byte) begin
				extram_q <= 1'b0;
				sg1000_q <= (ioctl_index_i[4:0] == cv_sys_pkg::SG1000_INDEX);
			end
			// Extra RAM when the 2000h block is all FFh
			if (in_extram_blk && sg1000_q) begin
				extram_q <= ((ioctl_addr_i[cv_sys_pkg::EXTRAM_BLOCK_LSB-1:0] == '0) | extram_q)
					& (&ioctl_dout_i);
			end
			cart_pages_q <= ioctl_addr_i[cv_sys_pkg::CART_PAGES_LSB +: cv_sys_pkg::CART_PAGES_W];
		end
	end

	// --------------------
	// RAM mirroring
	always_comb begin
		if (extram_q) begin
			ram_a_o = cpu_ram_a_i;
		end else if (ram_size_i == cv_sys_pkg::RAM_8K) begin
			ram_a_o = cpu_ram_a_i & cv_sys_pkg::RAM_MASK_8K;
		end else if (ram_size_i == cv_sys_pkg::RAM_1K) begin
			ram_a_o = cpu_ram_a_i & cv_sys_pkg::RAM_MASK_1K;
		end else if (ram_size_i == cv_sys_pkg::RAM_SGM && sg1000_q) begin
			ram_a_o = cpu_ram_a_i & cv_sys_pkg::RAM_MASK_8K; // SG-1000 tops out at 8K
		end else begin
			ram_a_o = cpu_ram_a_i; // Full 32K
		end
	end

	assign sg1000_o     = sg1000_q;
	assign extram_o     = extram_q;
	assign cart_pages_o = cart_pages_q;

endmodule

// File: verilog/cv_glue_top.sv
// Console glue top: config registers, key decoder, controller ports and memory map
module cv_glue_top (
	input  logic                     clk_sys,
	input  logic                     rst_n_i,

	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  logic [1:0]               wb_adr_i,
	input  logic [7:0]               wb_dat_i,
	output logic [7:0]               wb_dat_o,
	output logic                     wb_ack_o,

	input  cv_input_pkg::scan_code_t key_code_i,
	input  logic                     key_pressed_i,
	input  logic                     key_strobe_i,

	input  cv_input_pkg::pad_t       joy_a_i,
	input  cv_input_pkg::pad_t       joy_b_i,
	input  cv_input_pkg::port_sel_t  sel_a_i,
	input  cv_input_pkg::port_sel_t  sel_b_i,
	output cv_input_pkg::port_out_t  port_a_o,
	output cv_input_pkg::port_out_t  port_b_o,

	input  logic                     download_i,
	input  logic                     ioctl_wr_i,
	input  cv_sys_pkg::ioctl_addr_t  ioctl_addr_i,
	input  logic [7:0]               ioctl_dout_i,
	input  logic [7:0]               ioctl_index_i,

	input  cv_sys_pkg::cpu_addr_t    cpu_ram_a_i,
	output cv_sys_pkg::cpu_addr_t    ram_a_o,
	output logic                     sg1000_o,
	output logic                     extram_o,
	output cv_sys_pkg::cart_pages_t  cart_pages_o,
	output logic                     console_reset_o
);

	cv_sys_pkg::cfg_t       cfg;
	cv_input_pkg::kbd_btn_t kbd;

	cv_cfg_regs i_cfg_regs (
		.clk_sys         (clk_sys),
		.rst_n_i         (rst_n_i),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_dat_o        (wb_dat_o),
		.wb_ack_o        (wb_ack_o),
		.kbd_i           (kbd),
		.download_i      (download_i),
		.cfg_o           (cfg),
		.console_reset_o (console_reset_o)
	);

	cv_key_decoder i_key_decoder (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.key_code_i    (key_code_i),
		.key_pressed_i (key_pressed_i),
		.key_strobe_i  (key_strobe_i),
		.kbd_o         (kbd)
	);

	cv_ctrl_ports i_ctrl_ports (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.joy_a_i  (joy_a_i),
		.joy_b_i  (joy_b_i),
		.kbd_i    (kbd),
		.swap_i   (cfg.swap_joy),
		.sel_a_i  (sel_a_i),
		.sel_b_i  (sel_b_i),
		.port_a_o (port_a_o),
		.port_b_o (port_b_o)
	);

	cv_mem_map i_mem_map (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.ioctl_index_i (ioctl_index_i),
		.ram_size_i    (cfg.ram_size),
		.cpu_ram_a_i   (cpu_ram_a_i),
		.ram_a_o       (ram_a_o),
		.sg1000_o      (sg1000_o),
		.extram_o      (extram_o),
		.cart_pages_o  (cart_pages_o)
	);

endmodule

// File: verif/tb_cv_model.svh
// Reference model: key event update, pad merge, port encoding, RAM masking and loader tracking
`ifndef TB_CV_MODEL_SVH
`define TB_CV_MODEL_SVH

typedef struct packed {
	logic       sg1000;
	logic       extram;
	logic [5:0] pages;
} ldr_t;

// Held buttons after one PS/2 event
function automatic cv_input_pkg::kbd_btn_t key_update(cv_input_pkg::kbd_btn_t k,
	logic [7:0] code, logic pressed);
	logic [7:0] digit_sc [10];
	digit_sc = '{cv_input_pkg::SC_0, cv_input_pkg::SC_1, cv_input_pkg::SC_2, cv_input_pkg::SC_3,
		cv_input_pkg::SC_4, cv_input_pkg::SC_5, cv_input_pkg::SC_6, cv_input_pkg::SC_7,
		cv_input_pkg::SC_8, cv_input_pkg::SC_9};
	for (int i = 0; i < 10; i++) begin
		if (code == digit_sc[i])
			k.digits[i] = pressed;
	end
	case (code)
		cv_input_pkg::SC_STAR:   k.star  = pressed;
		cv_input_pkg::SC_MINUS:  k.minus = pressed;
		cv_input_pkg::SC_LSHIFT,
		cv_input_pkg::SC_RSHIFT: k.shift = pressed; // Either shift key
		cv_input_pkg::SC_UP:     k.up    = pressed;
		cv_input_pkg::SC_DOWN:   k.down  = pressed;
		cv_input_pkg::SC_LEFT:   k.left  = pressed;
		cv_input_pkg::SC_RIGHT:  k.right = pressed;
		cv_input_pkg::SC_FIRE1:  k.fire1 = pressed;
		cv_input_pkg::SC_FIRE2:  k.fire2 = pressed;
		cv_input_pkg::SC_CTRL:   k.ctrl  = pressed;
		cv_input_pkg::SC_ALT:    k.alt   = pressed;
		cv_input_pkg::SC_DEL:    k.del   = pressed;
		default: ;
	endcase
	return k;
endfunction

// Priority encoder, lowest key index wins
function automatic logic [3:0] keypad_expect(logic [13:0] keys);
	logic [3:0] codes [14];
	logic [3:0] code;
	codes = '{cv_input_pkg::KEY_0, cv_input_pkg::KEY_1, cv_input_pkg::KEY_2, cv_input_pkg::KEY_3,
		cv_input_pkg::KEY_4, cv_input_pkg::KEY_5, cv_input_pkg::KEY_6, cv_input_pkg::KEY_7,
		cv_input_pkg::KEY_8, cv_input_pkg::KEY_9, cv_input_pkg::KEY_STAR,
		cv_input_pkg::KEY_NUMBER, cv_input_pkg::KEY_PT, cv_input_pkg::KEY_BT};
	code = cv_input_pkg::KEY_NONE;
	for (int i = 13; i >= 0; i--) begin
		if (keys[i])
			code = codes[i];
	end
	return code;
endfunction

// Pad seen by one port after keyboard merge and swap
function automatic cv_input_pkg::pad_t pad_expect(cv_input_pkg::pad_t ja, cv_input_pkg::pad_t jb,
	cv_input_pkg::kbd_btn_t k, logic swap, logic port_b);
	cv_input_pkg::pad_t res;
	logic [13:0]        kb_keys;
	jb.up    = jb.up | k.up;
	jb.down  = jb.down | k.down;
	jb.left  = jb.left | k.left;
	jb.right = jb.right | k.right;
	jb.fire1 = jb.fire1 | k.fire1;
	jb.fire2 = jb.fire2 | k.fire2;
	kb_keys  = {2'b00, k.minus | (k.shift & k.digits[3]), k.star | (k.shift & k.digits[8]),
		k.digits};
	res      = (port_b ^ swap) ? jb : ja;
	res.keys = res.keys | kb_keys;
	return res;
endfunction

function automatic cv_input_pkg::port_out_t port_expect(cv_input_pkg::pad_t pad,
	cv_input_pkg::port_sel_t sel);
	cv_input_pkg::port_out_t r;
	r = '1;
	if (!sel.keypad_sel_n) begin
		r.lines  = r.lines & keypad_expect(pad.keys);
		r.fire_n = r.fire_n & ~pad.fire2;
	end
	if (!sel.joy_sel_n) begin
		r.lines  = r.lines & ~{pad.up, pad.right, pad.down, pad.left};
		r.fire_n = r.fire_n & ~pad.fire1;
	end
	return r;
endfunction

function automatic logic [14:0] mask_expect(logic [14:0] a, logic [1:0] size, ldr_t s);
	if (s.extram)
		return a;
	else if (size == 2'd1)
		return a & 15'h1FFF; // 8K
	else if (size == 2'd0)
		return a & 15'h03FF; // 1K
	else if (size == 2'd2 && s.sg1000)
		return a & 15'h1FFF;
	return a;
endfunction

// Loader state after one ioctl write
function automatic ldr_t loader_update(ldr_t s, logic [24:0] addr, logic [7:0] data,
	logic [7:0] index);
	ldr_t n;
	n = s;
	if (addr == 25'd0) begin
		n.sg1000 = (index[4:0] == 5'd2);
		n.extram = 1'b0;
	end
	if (addr[24:13] == 12'd1 && s.sg1000) // 2000h-3FFFh
		n.extram = (data == 8'hFF) && (addr[12:0] == 13'd0 || s.extram);
	n.pages = addr[19:14];
	return n;
endfunction

`endif

// File: verif/tb_cv_glue.sv
// Testbench for the console glue top: clock, reset, bus/key/loader tasks, random tests, report
module tb_cv_glue;

	logic                     clk_sys = 1'b0;
	logic                     rst_n_i;
	logic                     wb_cyc_i;
	logic                     wb_stb_i;
	logic                     wb_we_i;
	logic [1:0]               wb_adr_i;
	logic [7:0]               wb_dat_i;
	logic [7:0]               wb_dat_o;
	logic                     wb_ack_o;
	cv_input_pkg::scan_code_t key_code_i;
	logic                     key_pressed_i;
	logic                     key_strobe_i;
	cv_input_pkg::pad_t       joy_a_i;
	cv_input_pkg::pad_t       joy_b_i;
	cv_input_pkg::port_sel_t  sel_a_i;
	cv_input_pkg::port_sel_t  sel_b_i;
	cv_input_pkg::port_out_t  port_a_o;
	cv_input_pkg::port_out_t  port_b_o;
	logic                     download_i;
	logic                     ioctl_wr_i;
	cv_sys_pkg::ioctl_addr_t  ioctl_addr_i;
	logic [7:0]               ioctl_dout_i;
	logic [7:0]               ioctl_index_i;
	cv_sys_pkg::cpu_addr_t    cpu_ram_a_i;
	cv_sys_pkg::cpu_addr_t    ram_a_o;
	logic                     sg1000_o;
	logic                     extram_o;
	cv_sys_pkg::cart_pages_t  cart_pages_o;
	logic                     console_reset_o;

	`include "tb_cv_model.svh"

	localparam int TIMEOUT = 50; // Cycles per wait

	int                     err_cnt = 0;
	int                     test_err_base = 0;
	int                     tests_passed = 0;
	int                     tests_failed = 0;
	int                     reset_hits = 0;
	cv_input_pkg::kbd_btn_t kbd_m = '0; // Model keyboard
	ldr_t                   ldr_m = '0;
	logic                   swap_m = 1'b0;
	logic [1:0]             size_m = 2'd0;

	cv_glue_top i_dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (console_reset_o)
			reset_hits <= reset_hits + 1; // Catches one-cycle pulses
	end

	// --------------------
	// Helpers
	task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got == exp) else begin
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name);
		if (err_cnt == test_err_base) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, err_cnt - test_err_base);
		end
		test_err_base = err_cnt;
	endtask

	// One Wishbone classic cycle, starts and ends on a falling edge
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int n;
		n        = 0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdata;
		@(negedge clk_sys);
		while (!wb_ack_o && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!wb_ack_o) begin
			$display("Timeout: the Wishbone slave never acknowledged the cycle");
			err_cnt++;
		end
		rdata    = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(negedge clk_sys);
		assert (!wb_ack_o) else begin
			$display("Fail at %0t: ack held longer than one cycle", $time);
			err_cnt++;
		end
	endtask

	task automatic set_cfg(input logic [1:0] size, input logic swap, input logic rst);
		logic [7:0] unused_rd;
		bus_cycle(1'b1, 2'd0, {4'b0000, size, swap, rst}, unused_rd);
		size_m = size;
		swap_m = swap;
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_code_i    = code;
		key_pressed_i = pressed;
		key_strobe_i  = ~key_strobe_i; // One event per toggle
		kbd_m         = key_update(kbd_m, code, pressed);
		@(negedge clk_sys);
	endtask

	function automatic logic [7:0] digit_scan(input int d);
		logic [7:0] sc [10];
		sc = '{cv_input_pkg::SC_0, cv_input_pkg::SC_1, cv_input_pkg::SC_2, cv_input_pkg::SC_3,
			cv_input_pkg::SC_4, cv_input_pkg::SC_5, cv_input_pkg::SC_6, cv_input_pkg::SC_7,
			cv_input_pkg::SC_8, cv_input_pkg::SC_9};
		return sc[d];
	endfunction

	function automatic logic [7:0] pick_key(input logic dirs);
		logic [7:0] pad_sc [16];
		logic [7:0] dir_sc [8];
		pad_sc = '{cv_input_pkg::SC_0, cv_input_pkg::SC_1, cv_input_pkg::SC_2, cv_input_pkg::SC_3,
			cv_input_pkg::SC_4, cv_input_pkg::SC_5, cv_input_pkg::SC_6, cv_input_pkg::SC_7,
			cv_input_pkg::SC_8, cv_input_pkg::SC_9, cv_input_pkg::SC_STAR, cv_input_pkg::SC_MINUS,
			cv_input_pkg::SC_LSHIFT, cv_input_pkg::SC_RSHIFT, cv_input_pkg::SC_FIRE2, 8'h5A};
		dir_sc = '{cv_input_pkg::SC_UP, cv_input_pkg::SC_DOWN, cv_input_pkg::SC_LEFT,
			cv_input_pkg::SC_RIGHT, cv_input_pkg::SC_FIRE1, cv_input_pkg::SC_FIRE2,
			cv_input_pkg::SC_LSHIFT, 8'h5A};
		if (dirs)
			return dir_sc[3'($urandom)];
		return pad_sc[4'($urandom)];
	endfunction

	task automatic check_ports();
		cv_input_pkg::port_out_t exp_a;
		cv_input_pkg::port_out_t exp_b;
		exp_a = port_expect(pad_expect(joy_a_i, joy_b_i, kbd_m, swap_m, 1'b0), sel_a_i);
		exp_b = port_expect(pad_expect(joy_a_i, joy_b_i, kbd_m, swap_m, 1'b1), sel_b_i);
		compare_value(32'(port_a_o), 32'(exp_a), "port A");
		compare_value(32'(port_b_o), 32'(exp_b), "port B");
	endtask

	task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
		ioctl_wr_i   = 1'b1;
		ioctl_addr_i = addr;
		ioctl_dout_i = data;
		ldr_m        = loader_update(ldr_m, addr, data, ioctl_index_i);
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
	endtask

	// Sparse image: header byte, optional 2000h block, one last byte that sets the size
	task automatic load_image(input logic [7:0] index, input logic with_blk, input logic all_ff);
		download_i    = 1'b1;
		ioctl_index_i = index;
		write_byte(25'd0, 8'($urandom));
		if (with_blk) begin
			write_byte(25'h2000, all_ff ? 8'hFF : 8'($urandom));
			repeat (16)
				write_byte(25'h2000 | 25'(13'($urandom)), all_ff ? 8'hFF : 8'($urandom));
		end
		write_byte(25'(20'($urandom)), 8'($urandom));
		download_i = 1'b0;
	endtask

	task automatic await_reset(input int base, input string cause);
		int n;
		n = 0;
		while (reset_hits <= base && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (reset_hits <= base) begin
			$display("Timeout: console reset never rose for %s", cause);
			err_cnt++;
		end
	endtask

	task automatic await_reset_drop(input string cause);
		int n;
		n = 0;
		while (console_reset_o && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (console_reset_o) begin
			$display("Timeout: console reset stayed high after %s ended", cause);
			err_cnt++;
		end
	endtask

	// --------------------
	// Test sequence
	initial begin
		logic [7:0] rdata;
		logic [7:0] wdata;
		logic [7:0] reg_m;
		logic [1:0] adr;
		logic [1:0] rs;
		int         base;

		void'($urandom(97));
		rst_n_i       = 1'b0;
		wb_cyc_i      = 1'b0;
		wb_stb_i      = 1'b0;
		wb_we_i       = 1'b0;
		wb_adr_i      = 2'd0;
		wb_dat_i      = 8'd0;
		key_code_i    = 8'd0;
		key_pressed_i = 1'b0;
		key_strobe_i  = 1'b0;
		joy_a_i       = '0;
		joy_b_i       = '0;
		sel_a_i       = '1;
		sel_b_i       = '1;
		download_i    = 1'b0;
		ioctl_wr_i    = 1'b0;
		ioctl_addr_i  = '0;
		ioctl_dout_i  = 8'd0;
		ioctl_index_i = 8'd0;
		cpu_ram_a_i   = '0;
		reg_m         = 8'd0;
		repeat (4) @(negedge clk_sys);
		rst_n_i = 1'b1;
		@(negedge clk_sys);

		// Values out of reset
		compare_value(32'(wb_ack_o), 0, "ack after reset");
		compare_value(32'(console_reset_o), 0, "console reset after reset");
		compare_value(32'({sg1000_o, extram_o, cart_pages_o}), 0, "loader after reset");
		compare_value(32'({port_a_o, port_b_o}), 32'h3FF, "idle ports");
		bus_cycle(1'b0, 2'd0, 8'd0, rdata);
		compare_value(32'(rdata), 0, "config after reset");

		repeat (30) begin
			adr   = 2'($urandom);
			wdata = 8'($urandom);
			bus_cycle(1'b1, adr, wdata, rdata);
			if (adr == 2'd0)
				reg_m = {4'b0000, wdata[3:0]};
			adr = 2'($urandom);
			bus_cycle(1'b0, adr, 8'd0, rdata);
			compare_value(32'(rdata), (adr == 2'd0) ? 32'(reg_m) : 0, "register read");
		end
		set_cfg(2'd0, 1'b0, 1'b0);
		report_test("Wishbone registers");

		sel_a_i = 2'b01; // Keypad mode
		sel_b_i = 2'b01;
		repeat (40) begin
			repeat (1 + 2'($urandom))
				send_key(pick_key(1'b0), 1'($urandom));
			check_ports();
		end
		send_key(cv_input_pkg::SC_LSHIFT, 1'b1);
		for (int d = 0; d < 10; d++)
			send_key(digit_scan(d), 1'b0);
		send_key(cv_input_pkg::SC_8, 1'b1);
		check_ports(); // Shift with 8
		send_key(cv_input_pkg::SC_8, 1'b0);
		send_key(cv_input_pkg::SC_3, 1'b1);
		check_ports(); // Shift with 3
		report_test("Keypad encoding");

		repeat (30) begin
			set_cfg(2'd0, 1'($urandom), 1'b0);
			joy_a_i = cv_input_pkg::pad_t'(20'($urandom));
			joy_b_i = cv_input_pkg::pad_t'(20'($urandom));
			sel_a_i = {1'($urandom), 1'b0}; // Joystick, sometimes both modes
			sel_b_i = {1'($urandom), 1'b0};
			repeat (2)
				send_key(pick_key(1'b1), 1'($urandom));
			check_ports();
		end
		report_test("Joystick mode and swap");

		for (int i = 0; i < 10; i++) begin
			load_image((i < 3 || 1'($urandom)) ? {3'($urandom), 5'd2} : 8'($urandom),
				i < 3 || 1'($urandom), i < 2 || 1'($urandom));
			compare_value(32'(sg1000_o), 32'(ldr_m.sg1000), "sg1000");
			compare_value(32'(extram_o), 32'(ldr_m.extram), "extram");
			compare_value(32'(cart_pages_o), 32'(ldr_m.pages), "cart pages");
		end
		report_test("Cartridge loader");

		for (int i = 0; i < 8; i++) begin
			load_image((i % 2 == 0) ? 8'h02 : 8'($urandom), 1'($urandom), i < 2 || 1'($urandom));
			set_cfg(2'($urandom_range(0, 2)), 1'b0, 1'b0);
			repeat (20) begin
				cpu_ram_a_i = 15'($urandom);
				#1;
				compare_value(32'(ram_a_o), 32'(mask_expect(cpu_ram_a_i, size_m, ldr_m)),
					"RAM address");
				@(negedge clk_sys);
			end
		end
		report_test("Address masking");

		rs   = size_m;
		base = reset_hits;
		set_cfg(rs, 1'b0, 1'b1);
		await_reset(base, "the console reset bit");
		set_cfg(rs, 1'b0, 1'b0);
		await_reset_drop("the console reset bit");
		base = reset_hits;
		set_cfg((rs == 2'd0) ? 2'd1 : 2'd0, 1'b0, 1'b0); // RAM size change
		await_reset(base, "a RAM size change");
		await_reset_drop("a RAM size change");
		base = reset_hits;
		send_key(cv_input_pkg::SC_CTRL, 1'b1);
		send_key(cv_input_pkg::SC_ALT, 1'b1);
		send_key(cv_input_pkg::SC_DEL, 1'b1);
		await_reset(base, "ctrl+alt+del");
		send_key(cv_input_pkg::SC_DEL, 1'b0);
		await_reset_drop("ctrl+alt+del");
		base       = reset_hits;
		download_i = 1'b1;
		@(negedge clk_sys);
		await_reset(base, "an active download");
		download_i = 1'b0;
		await_reset_drop("an active download");
		report_test("Soft reset causes");

		$display("Tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+verif
verilog/cv_input_pkg.sv
verilog/cv_sys_pkg.sv
verilog/cv_cfg_regs.sv
verilog/cv_key_decoder.sv
verilog/cv_ctrl_ports.sv
verilog/cv_mem_map.sv
verilog/cv_glue_top.sv
verif/tb_cv_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the console glue testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cv_glue -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cv_glue > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^Test OK$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
